// File: slave_fifo.f
design/slave_fifo_pkg.sv
design/gpif_ep_if.sv
design/sync_fifo.sv
design/gpif_bus_master.sv
design/host_tx_buffers.sv
design/host_rx_buffers.sv
design/slave_fifo.sv
testbench/tb_clk_gen.sv
testbench/tb_slave_fifo.sv

// File: Bender.yml
package:
  name: slave_fifo

sources:
  - design/slave_fifo_pkg.sv
  - design/gpif_ep_if.sv
  - design/sync_fifo.sv
  - design/gpif_bus_master.sv
  - design/host_tx_buffers.sv
  - design/host_rx_buffers.sv
  - design/slave_fifo.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_slave_fifo.sv

// File: testbench/tb_slave_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module tb_slave_fifo;
   import slave_fifo_pkg::*;

   localparam int K_DATA_TX = 0;
   localparam int K_CTRL_TX = 1;
   localparam int K_DATA_RX = 2;
   localparam int K_CTRL_RX = 3;
   localparam int K_ZLP     = 4;
   localparam int N_ROWS    = 5;
   localparam int WAIT_LIMIT = 20000;

   // each table row holds kind, line count and sink ready mode
   // ready mode 1 toggles tx_ready_i at random and 0 keeps it high
   int tbl_kind  [N_ROWS] = '{K_DATA_TX, K_CTRL_TX, K_DATA_RX, K_CTRL_RX, K_ZLP};
   int tbl_lines [N_ROWS] = '{600, 2 * CTRL_PKT_LINES, 300, 8, 0};
   int tbl_ready [N_ROWS] = '{1, 0, 0, 0, 0};

   logic gpif_clk;
   logic gpif_rst;
   logic [LINE_W-1:0] gpif_d_i, gpif_d_o, tx_data_o, rx_data_i;
   logic [CTRL_W-1:0] ctrl_cmd_o, ctrl_resp_i;
   logic [3:0] gpif_ctl_i;
   logic [1:0] fifoadr_o;
   logic gpif_d_oe_o, sloe_o, slrd_o, slwr_o, pktend_o;
   logic dsp_rx_run_i, clear_tx_i, clear_rx_i;
   logic tx_valid_o, tx_ready_i, ctrl_cmd_valid_o, ctrl_cmd_ready_i;
   logic rx_valid_i, rx_ready_o, ctrl_resp_valid_i, ctrl_resp_ready_o;

   // bridge chip endpoint queues and expected results
   logic [LINE_W-1:0] ep2_q[$], ep4_q[$], rx_src[$], exp_tx[$], exp_ep6[$];
   logic [CTRL_W-1:0] resp_src[$], exp_cmd[$], exp_ep8[$];
   integer seed = 32'h24ef_cb3b;
   int zlp_count = 0;
   int ready_mode = 0;

   tb_clk_gen i_clk_gen (.clk_o(gpif_clk), .rst_o(gpif_rst));

   slave_fifo i_slave_fifo (.*);

   task automatic report_failure(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
         report_failure("value mismatch");
      end
   endtask

   function automatic bit phase_done(input int kind);
      case (kind)
         K_DATA_TX: return exp_tx.size() == 0;
         K_CTRL_TX: return exp_cmd.size() == 0;
         K_DATA_RX: return exp_ep6.size() == 0;
         K_CTRL_RX: return exp_ep8.size() == 0;
         default:   return zlp_count >= 1;
      endcase
   endfunction

   task automatic wait_phase(input int kind);
      int cycles;
      cycles = 0;
      while (!phase_done(kind))
      begin
         @(posedge gpif_clk);
         cycles++;
         if (cycles > WAIT_LIMIT)
            report_failure($sformatf("timeout waiting for table row of kind %0d", kind));
      end
   endtask

   //////////////////////////////////////////////////
   // bridge chip model and fabric sides driven on the falling edge

   always @(negedge gpif_clk)
   begin : model
      logic [LINE_W-1:0] head;
      if (!gpif_rst)
      begin
         check_value("slrd_o|slwr_o", slrd_o | slwr_o, 1);
         // design drives the bus whenever the chip does not
         check_value("gpif_d_oe_o", gpif_d_oe_o, sloe_o);
         // present the host read head word and pop it when slrd is low
         if (fifoadr_o == EP_CTRL_TX)
            head = (ep4_q.size() != 0) ? ep4_q[0] : '0;
         else
            head = (ep2_q.size() != 0) ? ep2_q[0] : '0;
         gpif_d_i = head;
         if (!slrd_o)
         begin
            check_value("sloe_o at read", sloe_o, 0);
            if (fifoadr_o == EP_CTRL_TX && ep4_q.size() != 0)
               void'(ep4_q.pop_front());
            else if (fifoadr_o == EP_DATA_TX && ep2_q.size() != 0)
               void'(ep2_q.pop_front());
            else
               report_failure("read strobe on an empty or wrong endpoint");
         end
         // host writes into endpoint 6 or 8
         if (!slwr_o)
         begin
            if (fifoadr_o == EP_DATA_RX && exp_ep6.size() != 0)
               check_value("gpif_d_o ep6", gpif_d_o, exp_ep6.pop_front());
            else if (fifoadr_o == EP_CTRL_RX && exp_ep8.size() != 0)
            begin
               check_value("gpif_d_o ep8", gpif_d_o, exp_ep8[0][LINE_W-1:0]);
               check_value("pktend_o ep8", pktend_o, !exp_ep8[0][CTRL_W-1]);
               void'(exp_ep8.pop_front());
            end
            else
               report_failure("unexpected write strobe from the DUT");
         end
         if (!pktend_o && fifoadr_o == EP_DATA_RX)
         begin
            check_value("slwr_o at zlp", slwr_o, 1);
            zlp_count++;
         end
         // flags already count the pop that lands on the next edge
         gpif_ctl_i = {2'b11, ep4_q.size() != 0, ep2_q.size() != 0};

         // data tx sink with its ready pattern
         tx_ready_i = ready_mode ? $random(seed) : 1'b1;
         if (tx_valid_o && tx_ready_i)
         begin
            if (exp_tx.size() == 0)
               report_failure("extra word on tx_data_o");
            check_value("tx_data_o", tx_data_o, exp_tx.pop_front());
         end
         if (ctrl_cmd_valid_o && ctrl_cmd_ready_i)
         begin
            if (exp_cmd.size() == 0)
               report_failure("extra word on ctrl_cmd_o");
            check_value("ctrl_cmd_o", ctrl_cmd_o, exp_cmd.pop_front());
         end

         // fabric sources let a word go when rx ready is seen now
         rx_valid_i = (rx_src.size() != 0);
         rx_data_i  = rx_valid_i ? rx_src[0] : '0;
         if (rx_valid_i && rx_ready_o)
            void'(rx_src.pop_front());
         ctrl_resp_valid_i = (resp_src.size() != 0);
         ctrl_resp_i       = ctrl_resp_valid_i ? resp_src[0] : '0;
         if (ctrl_resp_valid_i && ctrl_resp_ready_o)
            void'(resp_src.pop_front());
      end
   end

   //////////////////////////////////////////////////
   // sequencing over the table

   initial
   begin
      logic [LINE_W-1:0] w;
      int kind;
      int cycles;
      gpif_d_i = '0;
      gpif_ctl_i = 4'b1100;
      dsp_rx_run_i = 1'b1;
      clear_tx_i = 1'b0;
      clear_rx_i = 1'b0;
      tx_ready_i = 1'b1;
      ctrl_cmd_ready_i = 1'b1;
      rx_data_i = '0;
      rx_valid_i = 1'b0;
      ctrl_resp_i = '0;
      ctrl_resp_valid_i = 1'b0;

      cycles = 0;
      @(negedge gpif_clk);
      while (gpif_rst)
      begin
         @(negedge gpif_clk);
         cycles++;
         if (cycles > WAIT_LIMIT)
            report_failure("timeout waiting for reset release");
      end
      check_value("sloe_o", sloe_o, 1);
      check_value("slrd_o", slrd_o, 1);
      check_value("slwr_o", slwr_o, 1);
      check_value("pktend_o", pktend_o, 1);
      check_value("tx_valid_o", tx_valid_o, 0);
      check_value("ctrl_cmd_valid_o", ctrl_cmd_valid_o, 0);

      for (int r = 0; r < N_ROWS; r++)
      begin
         @(posedge gpif_clk);
         kind = tbl_kind[r];
         ready_mode = tbl_ready[r];
         for (int i = 0; i < tbl_lines[r]; i++)
         begin
            w = $random(seed);
            case (kind)
               K_DATA_TX:
               begin
                  ep2_q.push_back(w);
                  exp_tx.push_back(w);
               end
               K_CTRL_TX:
               begin
                  ep4_q.push_back(w);
                  exp_cmd.push_back({i % CTRL_PKT_LINES == CTRL_PKT_LINES - 1,
                                     i % CTRL_PKT_LINES == 0, w});
               end
               K_DATA_RX:
               begin
                  rx_src.push_back(w);
                  exp_ep6.push_back(w);
               end
               default:
               begin
                  // two responses of four words with the end mark on each last one
                  resp_src.push_back({i % 4 == 3, 1'b0, w});
                  exp_ep8.push_back({i % 4 == 3, 1'b0, w});
               end
            endcase
         end
         if (kind == K_ZLP)
         begin
            check_value("zlp_count before dsp stop", zlp_count, 0);
            @(negedge gpif_clk);
            dsp_rx_run_i = 1'b0;
         end
         wait_phase(kind);
      end

      // no second zero length commit without new rx data
      repeat (100) @(posedge gpif_clk);
      check_value("zlp_count", zlp_count, 1);

      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
   output logic clk_o,
   output logic rst_o
);

   // 10 ns period
   initial
   begin
      clk_o = 1'b0;
      forever
         #5 clk_o = ~clk_o;
   end

   // reset held for two rising edges, released after the second
   initial
   begin
      rst_o = 1'b1;
      repeat (2) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule

`default_nettype wire

// File: design/slave_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module slave_fifo (
   input  logic                               gpif_clk,
   input  logic                               gpif_rst,
   // usb bridge chip pins
   input  logic [slave_fifo_pkg::LINE_W-1:0]  gpif_d_i,
   output logic [slave_fifo_pkg::LINE_W-1:0]  gpif_d_o,
   output logic                               gpif_d_oe_o,
   input  logic [3:0]                         gpif_ctl_i,
   output logic                               sloe_o,
   output logic                               slrd_o,
   output logic                               slwr_o,
   output logic                               pktend_o,
   output logic [1:0]                         fifoadr_o,
   input  logic                               dsp_rx_run_i,
   input  logic                               clear_tx_i,
   input  logic                               clear_rx_i,
   // fabric streams
   output logic [slave_fifo_pkg::LINE_W-1:0]  tx_data_o,
   output logic                               tx_valid_o,
   input  logic                               tx_ready_i,
   output logic [slave_fifo_pkg::CTRL_W-1:0]  ctrl_cmd_o,
   output logic                               ctrl_cmd_valid_o,
   input  logic                               ctrl_cmd_ready_i,
   input  logic [slave_fifo_pkg::LINE_W-1:0]  rx_data_i,
   input  logic                               rx_valid_i,
   output logic                               rx_ready_o,
   input  logic [slave_fifo_pkg::CTRL_W-1:0]  ctrl_resp_i,
   input  logic                               ctrl_resp_valid_i,
   output logic                               ctrl_resp_ready_o
);

   // four endpoint channels between master and buffers
   gpif_ep_if i_ep ();

   gpif_bus_master i_bus_master (
      .gpif_clk     (gpif_clk),
      .gpif_rst     (gpif_rst),
      .gpif_d_i     (gpif_d_i),
      .gpif_ctl_i   (gpif_ctl_i),
      .dsp_rx_run_i (dsp_rx_run_i),
      .ep           (i_ep.master),
      .gpif_d_o     (gpif_d_o),
      .gpif_d_oe_o  (gpif_d_oe_o),
      .sloe_o       (sloe_o),
      .slrd_o       (slrd_o),
      .slwr_o       (slwr_o),
      .pktend_o     (pktend_o),
      .fifoadr_o    (fifoadr_o)
   );

   host_tx_buffers i_tx_buffers (
      .gpif_clk         (gpif_clk),
      .gpif_rst         (gpif_rst),
      .clear_tx_i       (clear_tx_i),
      .ep               (i_ep.tx_side),
      .tx_data_o        (tx_data_o),
      .tx_valid_o       (tx_valid_o),
      .tx_ready_i       (tx_ready_i),
      .ctrl_cmd_o       (ctrl_cmd_o),
      .ctrl_cmd_valid_o (ctrl_cmd_valid_o),
      .ctrl_cmd_ready_i (ctrl_cmd_ready_i)
   );

   host_rx_buffers i_rx_buffers (
      .gpif_clk          (gpif_clk),
      .gpif_rst          (gpif_rst),
      .clear_rx_i        (clear_rx_i),
      .ep                (i_ep.rx_side),
      .rx_data_i         (rx_data_i),
      .rx_valid_i        (rx_valid_i),
      .rx_ready_o        (rx_ready_o),
      .ctrl_resp_i       (ctrl_resp_i),
      .ctrl_resp_valid_i (ctrl_resp_valid_i),
      .ctrl_resp_ready_o (ctrl_resp_ready_o)
   );

endmodule

`default_nettype wire

// File: design/host_rx_buffers.sv
`timescale 1ns/10ps
`default_nettype none

module host_rx_buffers (
   input  logic                               gpif_clk,
   input  logic                               gpif_rst,
   input  logic                               clear_rx_i,
   gpif_ep_if.rx_side                         ep,
   input  logic [slave_fifo_pkg::LINE_W-1:0]  rx_data_i,
   input  logic                               rx_valid_i,
   output logic                               rx_ready_o,
   input  logic [slave_fifo_pkg::CTRL_W-1:0]  ctrl_resp_i,
   input  logic                               ctrl_resp_valid_i,
   output logic                               ctrl_resp_ready_o
);
   import slave_fifo_pkg::*;

   // dsp samples waiting for endpoint 6
   sync_fifo #(
      .WIDTH      (LINE_W),
      .DEPTH_LOG2 (DATA_FIFO_DEPTH_LOG2)
   ) i_drx_fifo (
      .clk_i      (gpif_clk),
      .rst_i      (gpif_rst),
      .clear_i    (clear_rx_i),
      .wr_data_i  (rx_data_i),
      .wr_valid_i (rx_valid_i),
      .wr_ready_o (rx_ready_o),
      .rd_data_o  (ep.drx_line),
      .rd_valid_o (ep.drx_avail),
      .rd_ready_i (ep.drx_rd),
      .space_o    ()
   );

   // responses for endpoint 8 with the end mark riding in the top bit
   sync_fifo #(
      .WIDTH      (CTRL_W),
      .DEPTH_LOG2 (CTRL_FIFO_DEPTH_LOG2)
   ) i_crx_fifo (
      .clk_i      (gpif_clk),
      .rst_i      (gpif_rst),
      .clear_i    (clear_rx_i),
      .wr_data_i  (ctrl_resp_i),
      .wr_valid_i (ctrl_resp_valid_i),
      .wr_ready_o (ctrl_resp_ready_o),
      .rd_data_o  (ep.crx_word),
      .rd_valid_o (ep.crx_avail),
      .rd_ready_i (ep.crx_rd),
      .space_o    ()
   );

endmodule

`default_nettype wire

// File: design/host_tx_buffers.sv
`timescale 1ns/10ps
`default_nettype none

module host_tx_buffers (
   input  logic                               gpif_clk,
   input  logic                               gpif_rst,
   input  logic                               clear_tx_i,
   gpif_ep_if.tx_side                         ep,
   output logic [slave_fifo_pkg::LINE_W-1:0]  tx_data_o,
   output logic                               tx_valid_o,
   input  logic                               tx_ready_i,
   output logic [slave_fifo_pkg::CTRL_W-1:0]  ctrl_cmd_o,
   output logic                               ctrl_cmd_valid_o,
   input  logic                               ctrl_cmd_ready_i
);
   import slave_fifo_pkg::*;

   logic [DATA_FIFO_DEPTH_LOG2:0] dtx_space;
   // position inside the current command packet
   logic [XFER_CNT_W-1:0]         cmd_line;
   logic                          cmd_sop;
   logic                          cmd_eop;

   //////////////////////////////////////////////////
   // data tx path

   sync_fifo #(
      .WIDTH      (LINE_W),
      .DEPTH_LOG2 (DATA_FIFO_DEPTH_LOG2)
   ) i_dtx_fifo (
      .clk_i      (gpif_clk),
      .rst_i      (gpif_rst),
      .clear_i    (clear_tx_i),
      .wr_data_i  (ep.wr_line),
      .wr_valid_i (ep.dtx_wr),
      .wr_ready_o (ep.dtx_room),
      .rd_data_o  (tx_data_o),
      .rd_valid_o (tx_valid_o),
      .rd_ready_i (tx_ready_i),
      .space_o    (dtx_space)
   );

   // a new burst only starts with room for a full one
   always_ff @(posedge gpif_clk)
   begin
      if (gpif_rst)
         ep.dtx_burst_ok <= 1'b0;
      else
         ep.dtx_burst_ok <= (dtx_space >= DATA_BURST_LINES);
   end

   //////////////////////////////////////////////////
   // ctrl command framing

   assign cmd_sop = (cmd_line == '0);
   assign cmd_eop = (cmd_line == XFER_CNT_W'(CTRL_PKT_LINES - 1));

   always_ff @(posedge gpif_clk)
   begin
      if (gpif_rst || clear_tx_i)
         cmd_line <= '0;
      else if (ep.ctx_wr)
         cmd_line <= cmd_eop ? '0 : cmd_line + 1'b1;
   end

   sync_fifo #(
      .WIDTH      (CTRL_W),
      .DEPTH_LOG2 (CTRL_FIFO_DEPTH_LOG2)
   ) i_ctx_fifo (
      .clk_i      (gpif_clk),
      .rst_i      (gpif_rst),
      .clear_i    (clear_tx_i),
      .wr_data_i  ({cmd_eop, cmd_sop, ep.wr_line}),
      .wr_valid_i (ep.ctx_wr),
      .wr_ready_o (ep.ctx_room),
      .rd_data_o  (ctrl_cmd_o),
      .rd_valid_o (ctrl_cmd_valid_o),
      .rd_ready_i (ctrl_cmd_ready_i),
      .space_o    ()
   );

endmodule

`default_nettype wire

// File: design/gpif_bus_master.sv
`timescale 1ns/10ps
`default_nettype none

module gpif_bus_master (
   input  logic                               gpif_clk,
   input  logic                               gpif_rst,
   input  logic [slave_fifo_pkg::LINE_W-1:0]  gpif_d_i,
   input  logic [3:0]                         gpif_ctl_i,
   input  logic                               dsp_rx_run_i,
   gpif_ep_if.master                          ep,
   output logic [slave_fifo_pkg::LINE_W-1:0]  gpif_d_o,
   output logic                               gpif_d_oe_o,
   output logic                               sloe_o,
   output logic                               slrd_o,
   output logic                               slwr_o,
   output logic                               pktend_o,
   output logic [1:0]                         fifoadr_o
);
   import slave_fifo_pkg::*;

   // chip flags after one register stage and turned active high
   logic ep2_empty;
   logic ep4_empty;
   logic ep6_full;
   logic ep8_full;

   gpif_state_e           state;
   logic [XFER_CNT_W-1:0] xfer_cnt;
   bus_hog_e              last_hog;
   // set by any data rx word, cleared by the zero length commit
   logic                  pktend_latch;

   logic     data_left;
   logic     dtx_fire;
   logic     ctx_fire;
   logic     drx_fire;
   logic     crx_fire;
   ep_addr_e ep_sel;

   always_ff @(posedge gpif_clk)
   begin
      if (gpif_rst)
      begin
         // treat chip as empty and full until the flags are sampled
         {ep8_full, ep6_full, ep4_empty, ep2_empty} <= 4'b1111;
      end
      else
      begin
         ep2_empty <= ~gpif_ctl_i[0];
         ep4_empty <= ~gpif_ctl_i[1];
         ep6_full  <= ~gpif_ctl_i[2];
         ep8_full  <= ~gpif_ctl_i[3];
      end
   end

   //////////////////////////////////////////////////
   // per cycle transfer qualifiers

   // data bursts stop at the fairness cap
   assign data_left = (xfer_cnt != XFER_CNT_W'(DATA_BURST_LINES));

   assign dtx_fire = (state == ST_DATA_TX) && !ep2_empty && ep.dtx_room && data_left;
   assign ctx_fire = (state == ST_CTRL_TX) && !ep4_empty && ep.ctx_room;
   assign drx_fire = (state == ST_DATA_RX) && !ep6_full && ep.drx_avail && data_left;
   assign crx_fire = (state == ST_CTRL_RX) && !ep8_full && ep.crx_avail;

   assign ep.dtx_wr  = dtx_fire;
   assign ep.ctx_wr  = ctx_fire;
   assign ep.drx_rd  = drx_fire;
   assign ep.crx_rd  = crx_fire;
   // the fifo write edge is the same edge the chip read strobe lands on
   assign ep.wr_line = gpif_d_i;

   //////////////////////////////////////////////////
   // bus master fsm

   always_ff @(posedge gpif_clk)
   begin
      if (gpif_rst)
      begin
         state        <= ST_IDLE;
         xfer_cnt     <= '0;
         last_hog     <= HOG_RX;
         pktend_latch <= 1'b0;
      end
      else
      begin
         if (state == ST_PKTEND)
            pktend_latch <= 1'b0;
         // a fresh word wins over the clear
         if (ep.drx_avail)
            pktend_latch <= 1'b1;

         case (state)
            ST_IDLE:
            begin
               xfer_cnt <= '0;
               // ctrl first, then data with the other direction preferred
               if (ep.ctx_room && !ep4_empty)
                  state <= ST_CTRL_TX_OE;
               else if (ep.crx_avail && !ep8_full)
                  state <= ST_CTRL_RX_ADR;
               else if (ep.dtx_room && ep.dtx_burst_ok && !ep2_empty && last_hog == HOG_RX)
                  state <= ST_DATA_TX_OE;
               else if (ep.drx_avail && !ep6_full && last_hog == HOG_TX)
                  state <= ST_DATA_RX_ADR;
               else if (ep.dtx_room && ep.dtx_burst_ok && !ep2_empty)
                  state <= ST_DATA_TX_OE;
               else if (ep.drx_avail && !ep6_full)
                  state <= ST_DATA_RX_ADR;
               else if (!ep.drx_avail && !dsp_rx_run_i && pktend_latch && !ep6_full)
                  state <= ST_PKTEND_ADR;
            end
            // sloe goes low one cycle ahead of slrd
            ST_DATA_TX_OE:
               state <= ST_DATA_TX;
            ST_CTRL_TX_OE:
               state <= ST_CTRL_TX;
            // fifoadr settles one cycle ahead of slwr
            ST_DATA_RX_ADR:
               state <= ST_DATA_RX;
            ST_CTRL_RX_ADR:
               state <= ST_CTRL_RX;
            ST_PKTEND_ADR:
               state <= ST_PKTEND;
            ST_DATA_TX:
            begin
               last_hog <= HOG_TX;
               if (dtx_fire)
                  xfer_cnt <= xfer_cnt + 1'b1;
               else
                  state <= ST_IDLE;
            end
            ST_DATA_RX:
            begin
               last_hog <= HOG_RX;
               if (drx_fire)
                  xfer_cnt <= xfer_cnt + 1'b1;
               else
                  state <= ST_IDLE;
            end
            ST_CTRL_TX:
            begin
               if (!ctx_fire)
                  state <= ST_IDLE;
            end
            ST_CTRL_RX:
            begin
               if (!crx_fire)
                  state <= ST_IDLE;
            end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // chip pins

   always_comb
   begin
      case (state)
         ST_CTRL_TX_OE, ST_CTRL_TX:
            ep_sel = EP_CTRL_TX;
         ST_DATA_RX_ADR, ST_DATA_RX, ST_PKTEND_ADR, ST_PKTEND:
            ep_sel = EP_DATA_RX;
         ST_CTRL_RX_ADR, ST_CTRL_RX:
            ep_sel = EP_CTRL_RX;
         default:
            ep_sel = EP_DATA_TX;
      endcase
   end

   assign fifoadr_o = ep_sel;

   // chip drives the bus only while sloe is low
   assign sloe_o = !(state == ST_DATA_TX_OE || state == ST_DATA_TX ||
                     state == ST_CTRL_TX_OE || state == ST_CTRL_TX);
   assign gpif_d_oe_o = sloe_o;

   assign slrd_o = !(dtx_fire || ctx_fire);
   assign slwr_o = !(drx_fire || crx_fire);

   // commit ctrl packet on its end word, or when responses run dry
   assign pktend_o = !((state == ST_CTRL_RX &&
                        ((crx_fire && ep.crx_word[CTRL_W-1]) || !ep.crx_avail)) ||
                       state == ST_PKTEND);

   assign gpif_d_o = (ep_sel == EP_CTRL_RX) ? ep.crx_word[LINE_W-1:0] : ep.drx_line;

   // bus turns one way per cycle
   a_rd_wr_excl: assert property (@(posedge gpif_clk) disable iff (gpif_rst)
      slrd_o || slwr_o);

   // strobes honor the flags that the buffer modules present
   a_strobe_flow: assert property (@(posedge gpif_clk) disable iff (gpif_rst)
      (!ep.dtx_wr || ep.dtx_room) && (!ep.ctx_wr || ep.ctx_room) &&
      (!ep.drx_rd || ep.drx_avail) && (!ep.crx_rd || ep.crx_avail));

endmodule

`default_nettype wire

// File: design/sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
   parameter int WIDTH      = 16,
   parameter int DEPTH_LOG2 = 9
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  clear_i,
   input  logic [WIDTH-1:0]      wr_data_i,
   input  logic                  wr_valid_i,
   output logic                  wr_ready_o,
   output logic [WIDTH-1:0]      rd_data_o,
   output logic                  rd_valid_o,
   input  logic                  rd_ready_i,
   output logic [DEPTH_LOG2:0]   space_o
);

   localparam logic [DEPTH_LOG2:0] DEPTH = 1 << DEPTH_LOG2;

   // payload storage
   logic [WIDTH-1:0]    mem [DEPTH];

   // one extra pointer bit tells full from empty
   logic [DEPTH_LOG2:0] wr_ptr;
   logic [DEPTH_LOG2:0] rd_ptr;
   logic [DEPTH_LOG2:0] level;
   logic                do_wr;
   logic                do_rd;

   assign level      = wr_ptr - rd_ptr;
   assign wr_ready_o = (level != DEPTH);
   assign rd_valid_o = (level != '0);
   assign space_o    = DEPTH - level;

   assign do_wr = wr_valid_i && wr_ready_o;
   assign do_rd = rd_valid_o && rd_ready_i;

   // head word falls through straight from the array
   assign rd_data_o = mem[rd_ptr[DEPTH_LOG2-1:0]];

   always_ff @(posedge clk_i)
   begin
      if (do_wr)
         mem[wr_ptr[DEPTH_LOG2-1:0]] <= wr_data_i;
   end

   //////////////////////////////////////////////////
   // pointers

   always_ff @(posedge clk_i)
   begin
      if (rst_i || clear_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // occupancy never runs past the array, so no write lands while full
   a_no_overfill: assert property (@(posedge clk_i) disable iff (rst_i)
      level <= DEPTH);

endmodule

`default_nettype wire

// File: design/gpif_ep_if.sv
`timescale 1ns/10ps
`default_nettype none

interface gpif_ep_if;
   import slave_fifo_pkg::*;

   // data tx channel from host to fabric
   logic              dtx_room;
   logic              dtx_burst_ok;
   logic              dtx_wr;
   // ctrl tx channel for host commands
   logic              ctx_room;
   logic              ctx_wr;
   // line taken off the chip bus and shared by both tx channels
   logic [LINE_W-1:0] wr_line;

   // data rx channel from fabric to host
   logic              drx_avail;
   logic [LINE_W-1:0] drx_line;
   logic              drx_rd;
   // ctrl rx channel carrying responses with the end mark in bit 17
   logic              crx_avail;
   logic [CTRL_W-1:0] crx_word;
   logic              crx_rd;

   modport master (
      input  dtx_room, dtx_burst_ok, ctx_room,
      input  drx_avail, drx_line, crx_avail, crx_word,
      output dtx_wr, ctx_wr, wr_line, drx_rd, crx_rd
   );

   modport tx_side (
      output dtx_room, dtx_burst_ok, ctx_room,
      input  dtx_wr, ctx_wr, wr_line
   );

   modport rx_side (
      output drx_avail, drx_line, crx_avail, crx_word,
      input  drx_rd, crx_rd
   );

endinterface

`default_nettype wire

// File: design/slave_fifo_pkg.sv
`default_nettype none

package slave_fifo_pkg;

   //////////////////////////////////////////////////
   // widths and depths

   // one 16 bit line on the chip bus
   localparam int LINE_W = 16;
   // ctrl word carries the line plus start and end marks
   localparam int CTRL_W = 18;
   // cap on a data burst so rx and tx share the bus fairly
   localparam int DATA_BURST_LINES = 256;
   // every host command packet is this many lines
   localparam int CTRL_PKT_LINES = 16;
   localparam int DATA_FIFO_DEPTH_LOG2 = 9;
   localparam int CTRL_FIFO_DEPTH_LOG2 = 5;
   // must hold DATA_BURST_LINES
   localparam int XFER_CNT_W = 10;

   //////////////////////////////////////////////////
   // encodings

   // fifoadr code of each chip endpoint
   typedef enum logic [1:0] {
      EP_DATA_TX = 2'b00,
      EP_CTRL_TX = 2'b01,
      EP_DATA_RX = 2'b10,
      EP_CTRL_RX = 2'b11
   } ep_addr_e;

   typedef enum logic [3:0] {
      ST_IDLE,
      ST_DATA_TX_OE,
      ST_DATA_TX,
      ST_CTRL_TX_OE,
      ST_CTRL_TX,
      ST_DATA_RX_ADR,
      ST_DATA_RX,
      ST_CTRL_RX_ADR,
      ST_CTRL_RX,
      ST_PKTEND_ADR,
      ST_PKTEND
   } gpif_state_e;

   // last direction that owned the bus for data
   typedef enum logic {
      HOG_RX = 1'b0,
      HOG_TX = 1'b1
   } bus_hog_e;

endpackage

`default_nettype wire
